/* tb/tensor_cases.txt */
// first word: number of tests; per test: reset mode n_instr n_beats (mode 0 ready, 1 random, 2 hold)
// instruction: op step wid rd a0..a7 b0..b7 c0..c7; beat: wid rd phase d0..d7
6
// test 1: single pair, warp 0, step 0
0 0 2 2
0 0 0 03 1 2 3 4 5 6 7 8 1 2 3 4 5 6 7 8 100 200 300 400 500 600 700 800
1 0 0 04 9 a b c d e f 10 8 7 6 5 4 3 2 1 1000 2000 3000 4000 5000 6000 7000 8000
0 03 0 149 252 339 442 56d 676 75d 866
0 04 1 1041 204a 3031 403a 5065 606e 7055 805e
// test 2: step s on warp s
0 0 8 8
0 0 0 05 1 2 3 4 5 6 7 8 1 2 3 4 5 6 7 8 100 200 300 400 500 600 700 800
1 0 0 06 9 a b c d e f 10 8 7 6 5 4 3 2 1 1000 2000 3000 4000 5000 6000 7000 8000
0 1 1 07 1 2 3 4 5 6 7 8 1 2 3 4 5 6 7 8 100 200 300 400 500 600 700 800
1 1 1 08 9 a b c d e f 10 8 7 6 5 4 3 2 1 1000 2000 3000 4000 5000 6000 7000 8000
0 2 2 09 1 2 3 4 5 6 7 8 1 2 3 4 5 6 7 8 100 200 300 400 500 600 700 800
1 2 2 0a 9 a b c d e f 10 8 7 6 5 4 3 2 1 1000 2000 3000 4000 5000 6000 7000 8000
0 3 3 0b 1 2 3 4 5 6 7 8 1 2 3 4 5 6 7 8 100 200 300 400 500 600 700 800
1 3 3 0c 9 a b c d e f 10 8 7 6 5 4 3 2 1 1000 2000 3000 4000 5000 6000 7000 8000
0 05 0 149 252 339 442 56d 676 75d 866
0 06 1 1041 204a 3031 403a 5065 606e 7055 805e
1 07 0 15b 264 34b 454 57f 688 76f 878
1 08 1 1053 205c 3043 404c 5077 6080 7067 8070
2 09 0 129 232 319 422 54d 656 73d 846
2 0a 1 1021 202a 3011 401a 5045 604e 7035 803e
3 0b 0 13b 244 32b 434 55f 668 74f 858
3 0c 1 1033 203c 3023 402c 5057 6060 7047 8050
// test 3: interleaved loads on warps 0 and 1, warp 1 multiplies first
0 0 4 4
0 0 0 01 1 2 3 4 5 6 7 8 1 2 3 4 5 6 7 8 100 200 300 400 500 600 700 800
0 0 1 02 2 3 4 5 6 7 8 9 1 2 3 4 5 6 7 8 100 200 300 400 500 600 700 800
1 0 1 11 9 a b c d e f 10 8 7 6 5 4 3 2 1 1000 2000 3000 4000 5000 6000 7000 8000
1 0 0 12 9 a b c d e f 10 8 7 6 5 4 3 2 1 1000 2000 3000 4000 5000 6000 7000 8000
1 02 0 14a 253 33c 445 56e 677 760 869
1 11 1 1043 204c 3035 403e 5067 6070 7059 8062
0 01 0 149 252 339 442 56d 676 75d 866
0 12 1 1041 204a 3031 403a 5065 606e 7055 805e
// test 4: random out_ready, warps 2 and 3
0 1 8 8
0 0 2 13 1 2 3 4 5 6 7 8 1 2 3 4 5 6 7 8 100 200 300 400 500 600 700 800
1 0 2 14 9 a b c d e f 10 8 7 6 5 4 3 2 1 1000 2000 3000 4000 5000 6000 7000 8000
0 1 3 15 1 2 3 4 5 6 7 8 1 2 3 4 5 6 7 8 100 200 300 400 500 600 700 800
1 1 3 16 9 a b c d e f 10 8 7 6 5 4 3 2 1 1000 2000 3000 4000 5000 6000 7000 8000
0 2 2 17 1 2 3 4 5 6 7 8 1 2 3 4 5 6 7 8 100 200 300 400 500 600 700 800
1 2 2 18 9 a b c d e f 10 8 7 6 5 4 3 2 1 1000 2000 3000 4000 5000 6000 7000 8000
0 3 3 19 1 2 3 4 5 6 7 8 1 2 3 4 5 6 7 8 100 200 300 400 500 600 700 800
1 3 3 1a 9 a b c d e f 10 8 7 6 5 4 3 2 1 1000 2000 3000 4000 5000 6000 7000 8000
2 13 0 149 252 339 442 56d 676 75d 866
2 14 1 1041 204a 3031 403a 5065 606e 7055 805e
3 15 0 15b 264 34b 454 57f 688 76f 878
3 16 1 1053 205c 3043 404c 5077 6080 7067 8070
2 17 0 129 232 319 422 54d 656 73d 846
2 18 1 1021 202a 3011 401a 5045 604e 7035 803e
3 19 0 13b 244 32b 434 55f 668 74f 858
3 1a 1 1033 203c 3023 402c 5057 6060 7047 8050
// test 5: out_ready held low, three pairs on warp 0
0 2 6 6
0 0 0 1b 1 2 3 4 5 6 7 8 1 2 3 4 5 6 7 8 100 200 300 400 500 600 700 800
1 0 0 1c 9 a b c d e f 10 8 7 6 5 4 3 2 1 1000 2000 3000 4000 5000 6000 7000 8000
0 1 0 1d 1 2 3 4 5 6 7 8 1 2 3 4 5 6 7 8 100 200 300 400 500 600 700 800
1 1 0 1e 9 a b c d e f 10 8 7 6 5 4 3 2 1 1000 2000 3000 4000 5000 6000 7000 8000
0 2 0 1f 1 2 3 4 5 6 7 8 1 2 3 4 5 6 7 8 100 200 300 400 500 600 700 800
1 2 0 00 9 a b c d e f 10 8 7 6 5 4 3 2 1 1000 2000 3000 4000 5000 6000 7000 8000
0 1b 0 149 252 339 442 56d 676 75d 866
0 1c 1 1041 204a 3031 403a 5065 606e 7055 805e
0 1d 0 15b 264 34b 454 57f 688 76f 878
0 1e 1 1053 205c 3043 404c 5077 6080 7067 8070
0 1f 0 129 232 319 422 54d 656 73d 846
0 00 1 1021 202a 3011 401a 5045 604e 7035 803e
// test 6: fresh reset, then the single pair again
1 0 2 2
0 0 0 03 1 2 3 4 5 6 7 8 1 2 3 4 5 6 7 8 100 200 300 400 500 600 700 800
1 0 0 04 9 a b c d e f 10 8 7 6 5 4 3 2 1 1000 2000 3000 4000 5000 6000 7000 8000
0 03 0 149 252 339 442 56d 676 75d 866
0 04 1 1041 204a 3031 403a 5065 606e 7055 805e

/* filelist.f */
+incdir+include
verilog/tensor_pkg.sv
verilog/sync_fifo.sv
verilog/operand_collector.sv
verilog/tensor_dpu.sv
verilog/writeback_sequencer.sv
verilog/tensor_octet_core.sv
tb/tensor_octet_tb.sv

/* Makefile */
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing -Wno-fatal
TOP       := tensor_octet_tb
FILELIST  := filelist.f

SOURCES   := $(filter-out +incdir%,$(shell cat $(FILELIST))) include/tensor_defs.svh
OBJ_DIR   := obj_dir
BIN       := $(OBJ_DIR)/V$(TOP)

.PHONY: all run clean

all: $(BIN)

$(BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

run: $(BIN)
	@out="$$(./$(BIN))"; echo "$$out"; echo "$$out" | grep -q "STATUS: PASS"

clean:
	rm -rf $(OBJ_DIR)

/* tb/tensor_octet_tb.sv */
`include "tensor_defs.svh"

module tensor_octet_tb;
    timeunit 1ns;
    timeprecision 1ps;

    localparam int timeout_cycles = 400;
    // instruction record is op, step, wid, rd, then 8 lanes each of a, b, c
    localparam int instr_words    = 28;
    // expected beat is wid, rd, phase, then 8 lanes of data
    localparam int beat_words     = 11;

    logic                    clk;
    logic                    reset;
    logic                    in_valid;
    tensor_pkg::tc_op_e      in_op;
    logic [1:0]              in_step;
    logic [`TC_NW_WIDTH-1:0] in_wid;
    logic [`TC_NR_BITS-1:0]  in_rd;
    tensor_pkg::lane_vec_t   in_a;
    tensor_pkg::lane_vec_t   in_b;
    tensor_pkg::lane_vec_t   in_c;
    logic                    in_ready;
    logic                    out_valid;
    logic [`TC_NW_WIDTH-1:0] out_wid;
    logic [`TC_NR_BITS-1:0]  out_rd;
    tensor_pkg::wb_phase_e   out_phase;
    tensor_pkg::lane_vec_t   out_data;
    logic                    out_ready;

    logic [31:0] cases_mem [0:2047];
    int          errors;
    int          test_errs;
    int          tests_run;
    int          tests_failed;
    bit          timed_out;
    bit          beats_done;

    tensor_octet_core tensor_octet_core_i (
        .clk       (clk),
        .reset     (reset),
        .in_valid  (in_valid),
        .in_op     (in_op),
        .in_step   (in_step),
        .in_wid    (in_wid),
        .in_rd     (in_rd),
        .in_a      (in_a),
        .in_b      (in_b),
        .in_c      (in_c),
        .in_ready  (in_ready),
        .out_valid (out_valid),
        .out_wid   (out_wid),
        .out_rd    (out_rd),
        .out_phase (out_phase),
        .out_data  (out_data),
        .out_ready (out_ready)
    );

    // 20 ns clock
    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    task automatic check_value(string what, logic [31:0] got, logic [31:0] exp);
        if (got !== exp) begin
            errors++;
            test_errs++;
            $display("ERR %0t: %s got %h expected %h", $time, what, got, exp);
        end
    endtask

    // two cycles of reset, then one idle cycle
    task automatic apply_reset();
        reset    <= 1'b1;
        in_valid <= 1'b0;
        repeat (2) @(posedge clk);
        reset <= 1'b0;
        @(posedge clk);
    endtask

    // put one instruction record on the input bus
    task automatic load_instr(int p);
        in_valid <= 1'b1;
        in_op    <= tensor_pkg::tc_op_e'(cases_mem[p][0]);
        in_step  <= cases_mem[p+1][1:0];
        in_wid   <= cases_mem[p+2][`TC_NW_WIDTH-1:0];
        in_rd    <= cases_mem[p+3][`TC_NR_BITS-1:0];
        for (int l = 0; l < `TC_LANES; l++) begin
            in_a[l] <= cases_mem[p+4+l];
            in_b[l] <= cases_mem[p+12+l];
            in_c[l] <= cases_mem[p+20+l];
        end
    endtask

    task automatic drive_instrs(int base, int n);
        int waited;
        for (int k = 0; k < n && !timed_out; k++) begin
            load_instr(base + k * instr_words);
            waited = 0;
            // in_ready seen at the edge is the value the transfer used
            do begin
                @(posedge clk);
                waited++;
            end while (!in_ready && waited < timeout_cycles);
            if (!in_ready) begin
                $display("timeout: instruction %0d was never accepted", k);
                timed_out = 1'b1;
            end
        end
        in_valid <= 1'b0;
    endtask

    task automatic collect_beats(int base, int n);
        int                    waited;
        int                    p;
        bit                    stalled;
        tensor_pkg::lane_vec_t held;
        stalled = 1'b0;
        held    = '0;
        for (int b = 0; b < n && !timed_out; b++) begin
            p      = base + b * beat_words;
            waited = 0;
            do begin
                @(posedge clk);
                waited++;
                // beat stalled on the last edge must be unchanged now
                if (stalled) begin
                    for (int l = 0; l < `TC_LANES; l++) begin
                        check_value("lane held during stall", out_data[l], held[l]);
                    end
                end
                stalled = out_valid && !out_ready;
                held    = out_data;
            end while (!(out_valid && out_ready) && waited < timeout_cycles);
            if (!(out_valid && out_ready)) begin
                $display("timeout: commit beat %0d never arrived", b);
                timed_out = 1'b1;
            end else begin
                check_value("beat wid", 32'(out_wid), cases_mem[p]);
                check_value("beat rd", 32'(out_rd), cases_mem[p+1]);
                check_value("beat phase", 32'(out_phase), cases_mem[p+2]);
                for (int l = 0; l < `TC_LANES; l++) begin
                    check_value($sformatf("beat %0d lane %0d", b, l), out_data[l],
                                cases_mem[p+3+l]);
                end
            end
        end
        beats_done = 1'b1;
    endtask

    // mode 0 always ready, 1 random, 2 held low until the input stalls behind a waiting beat
    task automatic control_ready(int mode);
        int waited;
        waited = 0;
        if (mode == 1) begin
            while (!beats_done && waited < timeout_cycles * 8) begin
                @(posedge clk);
                waited++;
                out_ready <= 1'($urandom % 2);
            end
            if (!beats_done) begin
                $display("timeout: random out_ready ran out before all beats arrived");
                timed_out = 1'b1;
            end
        end else if (mode == 2) begin
            out_ready <= 1'b0;
            // input must be held off while a beat sits on the low out_ready
            do begin
                @(posedge clk);
                waited++;
            end while (!(in_valid && !in_ready && out_valid) && waited < timeout_cycles);
            if (!(in_valid && !in_ready && out_valid)) begin
                $display("timeout: in_ready never dropped behind a held commit beat");
                timed_out = 1'b1;
            end
            out_ready <= 1'b1;
        end else begin
            out_ready <= 1'b1;
        end
    endtask

    initial begin
        int ntests;
        int ptr;
        int mode;
        int n_instr;
        int n_beats;
        int instr_base;
        reset        = 1'b1;
        in_valid     = 1'b0;
        in_op        = tensor_pkg::TC_OP_LOAD;
        in_step      = '0;
        in_wid       = '0;
        in_rd        = '0;
        in_a         = '0;
        in_b         = '0;
        in_c         = '0;
        out_ready    = 1'b1;
        errors       = 0;
        test_errs    = 0;
        tests_run    = 0;
        tests_failed = 0;
        timed_out    = 1'b0;
        void'($urandom(32'h6bdec5d6));
        $readmemh("tb/tensor_cases.txt", cases_mem);

        apply_reset();
        check_value("out_valid after reset", 32'(out_valid), 32'h0);

        ntests = cases_mem[0];
        ptr    = 1;
        for (int t = 0; t < ntests && !timed_out; t++) begin
            mode       = cases_mem[ptr+1];
            n_instr    = cases_mem[ptr+2];
            n_beats    = cases_mem[ptr+3];
            instr_base = ptr + 4;
            test_errs  = 0;
            if (cases_mem[ptr] != 0) begin
                apply_reset();
                check_value("out_valid after reset", 32'(out_valid), 32'h0);
            end
            beats_done = 1'b0;
            fork
                drive_instrs(instr_base, n_instr);
                collect_beats(instr_base + n_instr * instr_words, n_beats);
                control_ready(mode);
            join
            out_ready <= 1'b1;
            tests_run++;
            if (test_errs == 0 && !timed_out) begin
                $display("test %0d: ok", t + 1);
            end else begin
                tests_failed++;
                $display("test %0d: failed with %0d errors", t + 1, test_errs);
            end
            ptr = instr_base + n_instr * instr_words + n_beats * beat_words;
            repeat (3) @(posedge clk);
        end

        $display("tests run %0d, passed %0d, failed %0d, check errors %0d",
                 tests_run, tests_run - tests_failed, tests_failed, errors);
        if (errors == 0 && tests_failed == 0 && !timed_out && tests_run == ntests) begin
            $display("STATUS: PASS");
        end else begin
            $display("STATUS: FAIL");
        end
        $finish;
    end

endmodule

/* verilog/tensor_octet_core.sv */
`include "tensor_defs.svh"

module tensor_octet_core (
    input  logic                    clk,
    input  logic                    reset,
    input  logic                    in_valid,
    input  tensor_pkg::tc_op_e      in_op,
    input  logic [1:0]              in_step,
    input  logic [`TC_NW_WIDTH-1:0] in_wid,
    input  logic [`TC_NR_BITS-1:0]  in_rd,
    input  tensor_pkg::lane_vec_t   in_a,
    input  tensor_pkg::lane_vec_t   in_b,
    input  tensor_pkg::lane_vec_t   in_c,
    output logic                    in_ready,
    output logic                    out_valid,
    output logic [`TC_NW_WIDTH-1:0] out_wid,
    output logic [`TC_NR_BITS-1:0]  out_rd,
    output tensor_pkg::wb_phase_e   out_phase,
    output tensor_pkg::lane_vec_t   out_data,
    input  logic                    out_ready
);
    localparam int outq_w = $bits(tensor_pkg::acc_tile_t) + `TC_NW_WIDTH;

    logic                    accept;
    logic                    mul_valid;
    logic                    mul_ready;
    tensor_pkg::a_tile_t     a_tile;
    tensor_pkg::b_tile_t     b_tile;
    tensor_pkg::acc_tile_t   c_tile;
    logic [`TC_NW_WIDTH-1:0] mul_wid;
    logic                    res_push;
    tensor_pkg::acc_tile_t   d_tile;
    logic [`TC_NW_WIDTH-1:0] d_wid;
    logic                    outq_full;
    logic                    outq_empty;
    logic [outq_w-1:0]       outq_in;
    logic [outq_w-1:0]       outq_out;
    logic                    res_valid;
    tensor_pkg::acc_tile_t   res_tile;
    logic [`TC_NW_WIDTH-1:0] res_wid;
    logic                    res_pop;
    logic                    meta_full;

    // loads are held too while the dpu is stalled, which keeps pairs in step
    assign in_ready = mul_ready && !meta_full;
    assign accept   = in_valid && in_ready;

    operand_collector collector (
        .clk       (clk),
        .reset     (reset),
        .in_valid  (in_valid),
        .in_op     (in_op),
        .in_step   (in_step),
        .in_wid    (in_wid),
        .in_a      (in_a),
        .in_b      (in_b),
        .in_c      (in_c),
        .accept    (accept),
        .mul_valid (mul_valid),
        .a_tile    (a_tile),
        .b_tile    (b_tile),
        .c_tile    (c_tile),
        .mul_wid   (mul_wid)
    );

    // a full output queue freezes the dpu
    tensor_dpu dpu (
        .clk       (clk),
        .reset     (reset),
        .mul_valid (mul_valid),
        .a_tile    (a_tile),
        .b_tile    (b_tile),
        .c_tile    (c_tile),
        .mul_wid   (mul_wid),
        .mul_ready (mul_ready),
        .res_push  (res_push),
        .d_tile    (d_tile),
        .d_wid     (d_wid),
        .stall     (outq_full)
    );

    // staging for D while its two beats go out
    assign outq_in              = {d_wid, d_tile};
    assign {res_wid, res_tile}  = outq_out;
    assign res_valid            = !outq_empty;

    sync_fifo #(
        .depth (`TC_LATENCY_HMMA),
        .width (outq_w)
    ) out_q (
        .clk      (clk),
        .reset    (reset),
        .push     (res_push),
        .pop      (res_pop),
        .data_in  (outq_in),
        .data_out (outq_out),
        .full     (outq_full),
        .empty    (outq_empty)
    );

    writeback_sequencer sequencer (
        .clk       (clk),
        .reset     (reset),
        .accept    (accept),
        .in_wid    (in_wid),
        .in_rd     (in_rd),
        .res_valid (res_valid),
        .res_tile  (res_tile),
        .res_wid   (res_wid),
        .res_pop   (res_pop),
        .meta_full (meta_full),
        .out_valid (out_valid),
        .out_wid   (out_wid),
        .out_rd    (out_rd),
        .out_phase (out_phase),
        .out_data  (out_data),
        .out_ready (out_ready)
    );

endmodule

/* verilog/writeback_sequencer.sv */
`include "tensor_defs.svh"

module writeback_sequencer (
    input  logic                    clk,
    input  logic                    reset,
    input  logic                    accept,
    input  logic [`TC_NW_WIDTH-1:0] in_wid,
    input  logic [`TC_NR_BITS-1:0]  in_rd,
    input  logic                    res_valid,
    input  tensor_pkg::acc_tile_t   res_tile,
    input  logic [`TC_NW_WIDTH-1:0] res_wid,
    output logic                    res_pop,
    output logic                    meta_full,
    output logic                    out_valid,
    output logic [`TC_NW_WIDTH-1:0] out_wid,
    output logic [`TC_NR_BITS-1:0]  out_rd,
    output tensor_pkg::wb_phase_e   out_phase,
    output tensor_pkg::lane_vec_t   out_data,
    input  logic                    out_ready
);
    tensor_pkg::wb_phase_e    phase;
    logic                     beat_fire;
    logic [`TC_NR_BITS-1:0]   meta_rd [`TC_NUM_WARPS];
    logic [`TC_NUM_WARPS-1:0] meta_full_vec;
    logic [`TC_NUM_WARPS-1:0] meta_empty_vec;

    assign beat_fire = out_valid && out_ready;

    // one rd queue per warp
    // results of different warps can interleave at the input,
    // while the two beats of one result always commit back to back
    for (genvar w = 0; w < `TC_NUM_WARPS; w++) begin : g_meta
        sync_fifo #(
            .depth (`TC_META_DEPTH),
            .width (`TC_NR_BITS)
        ) meta_q (
            .clk      (clk),
            .reset    (reset),
            .push     (accept && (in_wid == `TC_NW_WIDTH'(w))),
            .pop      (beat_fire && (res_wid == `TC_NW_WIDTH'(w))),
            .data_in  (in_rd),
            .data_out (meta_rd[w]),
            .full     (meta_full_vec[w]),
            .empty    (meta_empty_vec[w])
        );
    end

    // any full warp queue holds off the whole input
    assign meta_full = |meta_full_vec;

    always_ff @(posedge clk) begin
        if (reset) begin
            phase <= tensor_pkg::WB_PHASE_EVEN;
        end else if (beat_fire) begin
            phase <= (phase == tensor_pkg::WB_PHASE_EVEN) ? tensor_pkg::WB_PHASE_ODD
                                                          : tensor_pkg::WB_PHASE_EVEN;
        end
    end

    // result tile leaves the output queue only after its odd beat
    assign res_pop   = beat_fire && (phase == tensor_pkg::WB_PHASE_ODD);

    assign out_valid = res_valid;
    assign out_wid   = res_wid;
    // even beat gets the load's rd, odd beat the mma's rd
    assign out_rd    = meta_rd[res_wid];
    assign out_phase = phase;

    // lanes 0-3 take rows 0,1 and lanes 4-7 rows 2,3
    // columns c and c+2, with c set by the phase
    always_comb begin
        int col;
        col = (phase == tensor_pkg::WB_PHASE_ODD) ? 1 : 0;
        for (int g = 0; g < 2; g++) begin
            out_data[4*g+0] = res_tile[2*g][col];
            out_data[4*g+1] = res_tile[2*g+1][col];
            out_data[4*g+2] = res_tile[2*g][col+2];
            out_data[4*g+3] = res_tile[2*g+1][col+2];
        end
    end

    // a stalled beat must not move
    a_beat_hold: assert property (@(posedge clk) disable iff (reset)
        (out_valid && !out_ready) |=> (out_valid && $stable(out_data)))
        else $error("commit beat changed while stalled");

    // every beat needs an rd queued at accept time
    a_meta_present: assert property (@(posedge clk) disable iff (reset)
        out_valid |-> !meta_empty_vec[res_wid])
        else $error("commit for warp %0d with no queued rd", res_wid);

endmodule

/* verilog/tensor_dpu.sv */
`include "tensor_defs.svh"

module tensor_dpu (
    input  logic                    clk,
    input  logic                    reset,
    input  logic                    mul_valid,
    input  tensor_pkg::a_tile_t     a_tile,
    input  tensor_pkg::b_tile_t     b_tile,
    input  tensor_pkg::acc_tile_t   c_tile,
    input  logic [`TC_NW_WIDTH-1:0] mul_wid,
    output logic                    mul_ready,
    output logic                    res_push,
    output tensor_pkg::acc_tile_t   d_tile,
    output logic [`TC_NW_WIDTH-1:0] d_wid,
    input  logic                    stall
);
    localparam int lat = `TC_LATENCY_HMMA;

    tensor_pkg::acc_tile_t   mac_tile;
    // result and warp id ride down the pipe together
    tensor_pkg::acc_tile_t   d_pipe [lat];
    logic [`TC_NW_WIDTH-1:0] wid_pipe [lat];
    logic [lat-1:0]          vld_pipe;
    logic                    issue;

    // whole pipe freezes, so nothing new enters while stalled
    assign mul_ready = !stall;
    assign issue     = mul_valid && mul_ready;

    // 4x4x2 multiply-accumulate, all products wrap at XLEN
    always_comb begin
        for (int i = 0; i < 4; i++) begin
            for (int j = 0; j < 4; j++) begin
                mac_tile[i][j] = c_tile[i][j]
                               + a_tile[i][0] * b_tile[0][j]
                               + a_tile[i][1] * b_tile[1][j];
            end
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            vld_pipe <= '0;
        end else if (!stall) begin
            vld_pipe[0] <= issue;
            for (int s = 1; s < lat; s++) begin
                vld_pipe[s] <= vld_pipe[s-1];
            end
        end
    end

    // payload stages, qualified by vld_pipe
    always_ff @(posedge clk) begin
        if (!stall) begin
            d_pipe[0]   <= mac_tile;
            wid_pipe[0] <= mul_wid;
            for (int s = 1; s < lat; s++) begin
                d_pipe[s]   <= d_pipe[s-1];
                wid_pipe[s] <= wid_pipe[s-1];
            end
        end
    end

    // last stage leaves on the same edge the pipe advances
    assign res_push = vld_pipe[lat-1] && !stall;
    assign d_tile   = d_pipe[lat-1];
    assign d_wid    = wid_pipe[lat-1];

endmodule

/* verilog/operand_collector.sv */
`include "tensor_defs.svh"

module operand_collector (
    input  logic                    clk,
    input  logic                    reset,
    input  logic                    in_valid,
    input  tensor_pkg::tc_op_e      in_op,
    input  logic [1:0]              in_step,
    input  logic [`TC_NW_WIDTH-1:0] in_wid,
    input  tensor_pkg::lane_vec_t   in_a,
    input  tensor_pkg::lane_vec_t   in_b,
    input  tensor_pkg::lane_vec_t   in_c,
    input  logic                    accept,
    output logic                    mul_valid,
    output tensor_pkg::a_tile_t     a_tile,
    output tensor_pkg::b_tile_t     b_tile,
    output tensor_pkg::acc_tile_t   c_tile,
    output logic [`TC_NW_WIDTH-1:0] mul_wid
);
    // halves picked out of the incoming lanes by the step bits
    logic [3:0][`TC_XLEN-1:0] a_half;
    logic [3:0][`TC_XLEN-1:0] b_half;

    // per-warp copies of the first instruction's halves
    logic [3:0][`TC_XLEN-1:0] a_buf [`TC_NUM_WARPS];
    logic [3:0][`TC_XLEN-1:0] b_buf [`TC_NUM_WARPS];
    tensor_pkg::lane_vec_t    c_buf [`TC_NUM_WARPS];

    // set once a warp has its first half buffered
    logic [`TC_NUM_WARPS-1:0] pending;
    logic                     load_fire;

    // step[0] picks A lanes 0,1,4,5 or 2,3,6,7 as rows 0..3
    assign a_half = in_step[0] ? {in_a[7:6], in_a[3:2]} : {in_a[5:4], in_a[1:0]};
    // step[1] picks the low or high four B lanes
    assign b_half = in_step[1] ? in_b[7:4] : in_b[3:0];

    assign load_fire = in_valid && accept && (in_op == tensor_pkg::TC_OP_LOAD);
    // second of the pair goes straight to the dpu on the same transfer
    assign mul_valid = in_valid && accept && (in_op == tensor_pkg::TC_OP_MMA);
    assign mul_wid   = in_wid;

    always_ff @(posedge clk) begin
        if (load_fire) begin
            a_buf[in_wid] <= a_half;
            b_buf[in_wid] <= b_half;
            // all C lanes are kept, the column split happens at assembly
            c_buf[in_wid] <= in_c;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            pending <= '0;
        end else begin
            if (load_fire) begin
                pending[in_wid] <= 1'b1;
            end
            if (mul_valid) begin
                pending[mul_wid] <= 1'b0;
            end
        end
    end

    // buffered half is column 0 of A and row 0 of B
    // live half is column 1 of A and row 1 of B
    always_comb begin
        int lo;
        for (int r = 0; r < 4; r++) begin
            a_tile[r][0] = a_buf[in_wid][r];
            a_tile[r][1] = a_half[r];
        end
        b_tile[0] = b_buf[in_wid];
        b_tile[1] = b_half;
        // C row r draws on lanes r, r+2 for the top rows and r+2, r+4 below
        for (int r = 0; r < 4; r++) begin
            lo = (r < 2) ? r : r + 2;
            c_tile[r][0] = c_buf[in_wid][lo];
            c_tile[r][1] = in_c[lo];
            c_tile[r][2] = c_buf[in_wid][lo + 2];
            c_tile[r][3] = in_c[lo + 2];
        end
    end

    // an mma without its load half would multiply stale buffer contents
    a_pair_order: assert property (@(posedge clk) disable iff (reset)
        mul_valid |-> pending[mul_wid])
        else $error("mma issued for warp %0d without a buffered first half", mul_wid);

endmodule

/* verilog/sync_fifo.sv */
`include "tensor_defs.svh"

module sync_fifo #(
    parameter int depth = `TC_META_DEPTH,
    parameter int width = `TC_XLEN
) (
    input  logic             clk,
    input  logic             reset,
    input  logic             push,
    input  logic             pop,
    input  logic [width-1:0] data_in,
    output logic [width-1:0] data_out,
    output logic             full,
    output logic             empty
);
    localparam int ptr_w = (depth > 1) ? $clog2(depth) : 1;
    localparam int cnt_w = $clog2(depth + 1);

    // circular storage with its read and write pointers and entry count
    logic [width-1:0] mem [depth];
    logic [ptr_w-1:0] wr_ptr;
    logic [ptr_w-1:0] rd_ptr;
    logic [cnt_w-1:0] count;

    assign full     = (count == cnt_w'(depth));
    assign empty    = (count == '0);
    // head is read straight out, so a push shows up one cycle later
    assign data_out = mem[rd_ptr];

    always_ff @(posedge clk) begin
        if (push) begin
            mem[wr_ptr] <= data_in;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            // pointers wrap at depth, not at a power of two
            if (push) begin
                wr_ptr <= (wr_ptr == ptr_w'(depth - 1)) ? '0 : wr_ptr + 1'b1;
            end
            if (pop) begin
                rd_ptr <= (rd_ptr == ptr_w'(depth - 1)) ? '0 : rd_ptr + 1'b1;
            end
            case ({push, pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    // the producer side must look at full before pushing
    a_no_overflow: assert property (@(posedge clk) disable iff (reset) !(push && full))
        else $error("sync_fifo push while full");

    // and the consumer side at empty before popping
    a_no_underflow: assert property (@(posedge clk) disable iff (reset) !(pop && empty))
        else $error("sync_fifo pop while empty");

endmodule

/* verilog/tensor_pkg.sv */
`include "tensor_defs.svh"

package tensor_pkg;

    // op of an instruction within its pair
    // load only fills the warp's half buffer, mma starts the multiply
    typedef enum logic {
        TC_OP_LOAD = 1'b0,
        TC_OP_MMA  = 1'b1
    } tc_op_e;

    // which columns of D the current commit beat carries
    typedef enum logic {
        WB_PHASE_EVEN = 1'b0,
        WB_PHASE_ODD  = 1'b1
    } wb_phase_e;

    // one word per lane of the octet
    typedef logic [`TC_LANES-1:0][`TC_XLEN-1:0] lane_vec_t;

    // A is 4x2, indexed [row][col]
    typedef logic [3:0][1:0][`TC_XLEN-1:0] a_tile_t;

    // B is 2x4, indexed [row][col]
    typedef logic [1:0][3:0][`TC_XLEN-1:0] b_tile_t;

    // C and D are both 4x4
    typedef logic [3:0][3:0][`TC_XLEN-1:0] acc_tile_t;

endpackage

/* include/tensor_defs.svh */
`ifndef TENSOR_DEFS_SVH
`define TENSOR_DEFS_SVH

// lanes in the single octet, one data word each
`define TC_LANES 8

// data word width, integer wrapping arithmetic
`define TC_XLEN 32

// warps sharing the octet
`define TC_NUM_WARPS 4
`define TC_NW_WIDTH 2

// destination register id width
`define TC_NR_BITS 5

// dot-product pipeline depth
// the output staging queue is sized to match
`define TC_LATENCY_HMMA 4

// per-warp metadata queue entries
// two per pair, so two pairs per warp in flight
`define TC_META_DEPTH 4

`endif
